/* verilog.f */
hw/tag_pkg.sv
hw/tag_converter.sv
hw/tag_fifo.sv
hw/tag_counter.sv
hw/tag_link_top.sv
tb/tag_fifo_sva.sv
tb/tb_tag_link.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_tag_link
FILELIST  ?= verilog.f

SIM  := obj_dir/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

/* tb/tb_tag_link.sv */
module tb_tag_link;
    import tag_pkg::*;

    // Bounds on one handshake wait and on idle polling rounds
    localparam int WAIT_LIMIT = 200;
    localparam int POLL_LIMIT = 50;
    // Rising counts, falling counts, then last time low and high
    localparam int WATCHED = 2 * NUM_CHANNELS + 2;

    typedef logic [TC_WORD_WIDTH-1:0][TAG_WORD_BITS-1:0] words_t;

    logic sys_clk;
    logic sys_clk_rst;
    logic tag_valid_i;
    words_t tag_words_i;
    logic [TC_WORD_WIDTH-1:0] tag_keep_i;
    logic [WRAP_BITS-1:0] tag_wrap_i;
    logic tag_ready_o;
    logic reg_cyc_i;
    logic reg_stb_i;
    logic reg_we_i;
    logic reg_ack_o;
    logic [REG_ADDR_BITS-1:0] reg_addr_i;
    logic [COUNT_BITS-1:0] reg_wdata_i;
    logic [COUNT_BITS-1:0] reg_rdata_o;

    // Reference model of the counter registers
    int unsigned exp_rise [NUM_CHANNELS];
    int unsigned exp_fall [NUM_CHANNELS];
    logic [TAG_TIME_BITS-1:0] exp_last_time;

    int error_count;
    int timeout_count;
    logic saw_backpressure;
    logic [31:0] rng_state;

    tag_link_top u_dut (.*);

    initial sys_clk = 1'b0;
    always #50 sys_clk = ~sys_clk;

    // Xorshift32 step on the shared state
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Counter banks are contiguous from the rising base
    function automatic logic [REG_ADDR_BITS-1:0] watched_addr(input int k);
        if (k < 2 * NUM_CHANNELS) begin
            return REG_RISE_BASE + REG_ADDR_BITS'(k);
        end
        return (k == 2 * NUM_CHANNELS) ? REG_LAST_TIME_LO : REG_LAST_TIME_HI;
    endfunction

    function automatic logic [COUNT_BITS-1:0] model_value(input int k);
        if (k < NUM_CHANNELS) begin
            return exp_rise[k];
        end else if (k < 2 * NUM_CHANNELS) begin
            return exp_fall[k - NUM_CHANNELS];
        end
        return (k == 2 * NUM_CHANNELS) ? exp_last_time[COUNT_BITS-1:0]
                                       : exp_last_time[TAG_TIME_BITS-1:COUNT_BITS];
    endfunction

    task automatic model_clear();
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            exp_rise[i] = 0;
            exp_fall[i] = 0;
        end
        exp_last_time = '0;
    endtask

    // Offer one beat, then fold it into the model once taken
    task automatic send_beat(input words_t words, input logic [TC_WORD_WIDTH-1:0] keep,
                             input logic [WRAP_BITS-1:0] wrap);
        int waited;
        int ch;
        logic taken;
        waited = 0;
        taken = 1'b0;
        tag_valid_i = 1'b1;
        tag_words_i = words;
        tag_keep_i = keep;
        tag_wrap_i = wrap;
        while (!taken && waited < WAIT_LIMIT) begin
            // Ready comes from registers only, settled since the last edge
            taken = tag_ready_o;
            saw_backpressure = saw_backpressure || !tag_ready_o;
            @(posedge sys_clk);
            #1;
            waited++;
        end
        tag_valid_i = 1'b0;
        if (!taken) begin
            $display("timeout: stream input was never ready to take a beat");
            timeout_count++;
        end else begin
            // Ascending lanes, so the highest kept lane leaves the last time
            for (int i = 0; i < TC_WORD_WIDTH; i++) begin
                if (keep[i]) begin
                    ch = int'($signed(words[i][TAG_WORD_BITS-1 -: CHANNEL_BITS]));
                    exp_last_time = TAG_TIME_BITS'({wrap, words[i][FINE_TIME_BITS-1:0]});
                    if (ch >= 1 && ch <= NUM_CHANNELS) begin
                        exp_rise[ch - 1]++;
                    end else if (ch <= -1 && ch >= -NUM_CHANNELS) begin
                        exp_fall[-ch - 1]++;
                    end
                end
            end
        end
    endtask

    // One register request, held until its single-cycle ack
    task automatic reg_cycle(input logic we, input logic [REG_ADDR_BITS-1:0] addr,
                             input logic [COUNT_BITS-1:0] wdata,
                             output logic [COUNT_BITS-1:0] rdata);
        int waited;
        waited = 0;
        reg_cyc_i = 1'b1;
        reg_stb_i = 1'b1;
        reg_we_i = we;
        reg_addr_i = addr;
        reg_wdata_i = wdata;
        do begin
            @(posedge sys_clk);
            #1;
            waited++;
        end while (!reg_ack_o && waited < WAIT_LIMIT);
        rdata = reg_rdata_o;
        // Strobe drops in the ack cycle
        reg_cyc_i = 1'b0;
        reg_stb_i = 1'b0;
        reg_we_i = 1'b0;
        if (!reg_ack_o) begin
            $display("timeout: register port gave no ack for address 0x%02h", addr);
            timeout_count++;
        end
    endtask

    task automatic reg_read(input logic [REG_ADDR_BITS-1:0] addr,
                            output logic [COUNT_BITS-1:0] data);
        reg_cycle(1'b0, addr, '0, data);
    endtask

    task automatic reg_write(input logic [REG_ADDR_BITS-1:0] addr,
                             input logic [COUNT_BITS-1:0] data);
        logic [COUNT_BITS-1:0] ignored;
        reg_cycle(1'b1, addr, data, ignored);
    endtask

    task automatic check_reg(input logic [REG_ADDR_BITS-1:0] addr,
                             input logic [COUNT_BITS-1:0] expected);
        logic [COUNT_BITS-1:0] got;
        reg_read(addr, got);
        assert (got === expected) else begin
            $display("error %0t: register 0x%02h expected 0x%08h actual 0x%08h",
                     $time, addr, expected, got);
            error_count++;
        end
    endtask

    task automatic check_model();
        for (int k = 0; k < WATCHED; k++) begin
            check_reg(watched_addr(k), model_value(k));
        end
    endtask

    // Poll until the pipeline has drained into the model's values
    task automatic wait_idle();
        logic [COUNT_BITS-1:0] got;
        logic same;
        int polls;
        polls = 0;
        do begin
            same = 1'b1;
            for (int k = 0; k < WATCHED; k++) begin
                reg_read(watched_addr(k), got);
                same = same && (got == model_value(k));
            end
            polls++;
        end while (!same && polls < POLL_LIMIT);
        if (!same) begin
            $display("timeout: counters never settled to the expected values");
            timeout_count++;
        end
    endtask

    task automatic identity_regs();
        check_reg(REG_ID, 32'd1);
        check_reg(REG_FIFO_DEPTH, 32'd16);
        // Unmapped address
        check_reg(8'h3a, 32'd0);
    endtask

    task automatic single_tag();
        words_t words;
        // Dropped lanes hold a countable channel that must stay uncounted
        for (int i = 0; i < TC_WORD_WIDTH; i++) begin
            words[i] = {6'd5, FINE_TIME_BITS'(next_random())};
        end
        words[2] = {6'd3, 26'h155};
        send_beat(words, 4'b0100, 32'd7);
        wait_idle();
        check_reg(REG_RISE_BASE + 8'd2, 32'd1);
        check_reg(REG_LAST_TIME_LO, (32'd7 << 26) + 32'h155);
        check_reg(REG_LAST_TIME_HI, 32'd0);
        check_model();
    endtask

    task automatic random_beats();
        words_t words;
        for (int b = 0; b < 30; b++) begin
            // Full 6-bit channel range, most of it uncounted
            for (int i = 0; i < TC_WORD_WIDTH; i++) begin
                words[i] = next_random();
            end
            if (b % 5 == 2) begin
                words[b % TC_WORD_WIDTH][TAG_WORD_BITS-1 -: CHANNEL_BITS] = '0;
            end
            send_beat(words, TC_WORD_WIDTH'(next_random()), next_random());
        end
        wait_idle();
        check_model();
    endtask

    task automatic backpressure_burst();
        words_t words;
        logic [COUNT_BITS-1:0] got;
        logic [31:0] r;
        int mag;
        int total;
        reg_write(REG_CLEAR, 32'd0);
        model_clear();
        saw_backpressure = 1'b0;
        for (int b = 0; b < 60; b++) begin
            // All lanes kept and in range, so every tag counts
            for (int i = 0; i < TC_WORD_WIDTH; i++) begin
                r = next_random();
                mag = int'(r % NUM_CHANNELS) + 1;
                words[i] = {CHANNEL_BITS'(r[31] ? -mag : mag), FINE_TIME_BITS'(r)};
            end
            send_beat(words, '1, WRAP_BITS'(b));
        end
        wait_idle();
        check_model();
        total = 0;
        for (int k = 0; k < 2 * NUM_CHANNELS; k++) begin
            reg_read(watched_addr(k), got);
            total += int'(got);
        end
        assert (total == 240) else begin
            $display("error %0t: counter total expected 240 actual %0d", $time, total);
            error_count++;
        end
        assert (saw_backpressure) else begin
            $display("tag_ready_o never dropped during the back-to-back burst");
            error_count++;
        end
    endtask

    task automatic clear_and_recount();
        words_t words;
        reg_write(REG_CLEAR, 32'd0);
        model_clear();
        for (int k = 0; k < WATCHED; k++) begin
            check_reg(watched_addr(k), 32'd0);
        end
        // Falling edge on channel 4, lane 1 only
        words = '0;
        words[1] = {CHANNEL_BITS'(-4), 26'h2a};
        send_beat(words, 4'b0010, 32'd1);
        wait_idle();
        check_reg(REG_FALL_BASE + 8'd3, 32'd1);
        check_model();
    endtask

    initial begin
        error_count = 0;
        timeout_count = 0;
        saw_backpressure = 1'b0;
        rng_state = 32'h2dd06d67;
        sys_clk_rst = 1'b1;
        tag_valid_i = 1'b0;
        tag_words_i = '0;
        tag_keep_i = '0;
        tag_wrap_i = '0;
        reg_cyc_i = 1'b0;
        reg_stb_i = 1'b0;
        reg_we_i = 1'b0;
        reg_addr_i = '0;
        reg_wdata_i = '0;
        model_clear();
        repeat (4) @(posedge sys_clk);
        #1;
        sys_clk_rst = 1'b0;
        assert (tag_ready_o === 1'b1 && reg_ack_o === 1'b0) else begin
            $display("DUT did not come out of reset ready and idle");
            error_count++;
        end
        identity_regs();
        single_tag();
        random_beats();
        backpressure_burst();
        clear_and_recount();
        $display("Closing: %0d errors, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* tb/tag_fifo_sva.sv */
module tag_fifo_sva #(
    parameter int DEPTH = tag_pkg::TAG_FIFO_DEPTH
) (
    input logic                   sys_clk,
    input logic                   sys_clk_rst,
    input logic [$clog2(DEPTH):0] count_i,
    input logic                   wr_valid_i,
    input logic                   wr_ready_i,
    input logic                   rd_valid_i,
    input logic                   rd_ready_i,
    input tag_pkg::tag_beat_t     rd_beat_i
);

    // Occupancy rebuilt from the handshakes on both sides
    int level;

    always_ff @(posedge sys_clk) begin
        if (sys_clk_rst) begin
            level <= 0;
        end else begin
            level <= level + int'(wr_valid_i && wr_ready_i) - int'(rd_valid_i && rd_ready_i);
        end
    end

    // Occupancy bounded by the depth
    occupancy_bound: assert property (@(posedge sys_clk) disable iff (sys_clk_rst)
        count_i <= DEPTH)
        else $error("FIFO occupancy above its depth");

    // Every accepted beat already read, so no head shown
    empty_not_valid: assert property (@(posedge sys_clk) disable iff (sys_clk_rst)
        level == 0 |-> !rd_valid_i)
        else $error("FIFO output valid while empty");

    // Room left means the writer is never stalled
    room_means_ready: assert property (@(posedge sys_clk) disable iff (sys_clk_rst)
        level < DEPTH |-> wr_ready_i)
        else $error("FIFO not ready while below depth");

    // Head entry held while the reader stalls
    head_stable: assert property (@(posedge sys_clk) disable iff (sys_clk_rst)
        rd_valid_i && !rd_ready_i |=> $stable(rd_beat_i))
        else $error("FIFO head changed while stalled");

endmodule

bind tag_fifo tag_fifo_sva #(.DEPTH(DEPTH)) u_fifo_sva (
    .sys_clk     (sys_clk),
    .sys_clk_rst (sys_clk_rst),
    .count_i     (count),
    .wr_valid_i  (wr_valid_i),
    .wr_ready_i  (wr_ready_o),
    .rd_valid_i  (rd_valid_o),
    .rd_ready_i  (rd_ready_i),
    .rd_beat_i   (rd_beat_o)
);

/* hw/tag_link_top.sv */
module tag_link_top (
    input  logic                                                         sys_clk,
    input  logic                                                         sys_clk_rst,
    // Tag word stream
    input  logic                                                         tag_valid_i,
    input  logic [tag_pkg::TC_WORD_WIDTH-1:0][tag_pkg::TAG_WORD_BITS-1:0] tag_words_i,
    input  logic [tag_pkg::TC_WORD_WIDTH-1:0]                            tag_keep_i,
    input  logic [tag_pkg::WRAP_BITS-1:0]                                tag_wrap_i,
    output logic                                                         tag_ready_o,
    // Register port
    input  logic                                                         reg_cyc_i,
    input  logic                                                         reg_stb_i,
    input  logic                                                         reg_we_i,
    input  logic [tag_pkg::REG_ADDR_BITS-1:0]                            reg_addr_i,
    input  logic [tag_pkg::COUNT_BITS-1:0]                               reg_wdata_i,
    output logic                                                         reg_ack_o,
    output logic [tag_pkg::COUNT_BITS-1:0]                               reg_rdata_o
);
    import tag_pkg::*;

    // Converter to FIFO
    logic      conv_valid;
    logic      conv_ready;
    tag_beat_t conv_beat;

    // FIFO to counter
    logic      fifo_valid;
    logic      fifo_ready;
    tag_beat_t fifo_beat;

    // Word decode, one register stage
    tag_converter u_converter (
        .sys_clk     (sys_clk),
        .sys_clk_rst (sys_clk_rst),
        .in_valid_i  (tag_valid_i),
        .in_keep_i   (tag_keep_i),
        .in_words_i  (tag_words_i),
        .in_wrap_i   (tag_wrap_i),
        .in_ready_o  (tag_ready_o),
        .out_valid_o (conv_valid),
        .out_beat_o  (conv_beat),
        .out_ready_i (conv_ready)
    );

    // Absorbs the counter's lane-by-lane pace
    tag_fifo #(
        .DEPTH(TAG_FIFO_DEPTH)
    ) u_fifo (
        .sys_clk     (sys_clk),
        .sys_clk_rst (sys_clk_rst),
        .wr_valid_i  (conv_valid),
        .wr_beat_i   (conv_beat),
        .wr_ready_o  (conv_ready),
        .rd_valid_o  (fifo_valid),
        .rd_beat_o   (fifo_beat),
        .rd_ready_i  (fifo_ready)
    );

    tag_counter u_counter (
        .sys_clk     (sys_clk),
        .sys_clk_rst (sys_clk_rst),
        .in_valid_i  (fifo_valid),
        .in_beat_i   (fifo_beat),
        .in_ready_o  (fifo_ready),
        .reg_cyc_i   (reg_cyc_i),
        .reg_stb_i   (reg_stb_i),
        .reg_we_i    (reg_we_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .reg_ack_o   (reg_ack_o),
        .reg_rdata_o (reg_rdata_o)
    );

endmodule

/* hw/tag_counter.sv */
module tag_counter (
    input  logic                              sys_clk,
    input  logic                              sys_clk_rst,
    input  logic                              in_valid_i,
    input  tag_pkg::tag_beat_t                in_beat_i,
    output logic                              in_ready_o,
    input  logic                              reg_cyc_i,
    input  logic                              reg_stb_i,
    input  logic                              reg_we_i,
    input  logic [tag_pkg::REG_ADDR_BITS-1:0] reg_addr_i,
    input  logic [tag_pkg::COUNT_BITS-1:0]    reg_wdata_i,
    output logic                              reg_ack_o,
    output logic [tag_pkg::COUNT_BITS-1:0]    reg_rdata_o
);
    import tag_pkg::*;

    localparam int LANE_BITS = $clog2(TC_WORD_WIDTH);
    localparam int IDX_BITS = $clog2(NUM_CHANNELS);
    localparam logic [CHANNEL_BITS-1:0] MAX_CH = CHANNEL_BITS'(NUM_CHANNELS);

    // Lane walk state
    logic [TC_WORD_WIDTH-1:0] lane_done;
    logic [TC_WORD_WIDTH-1:0] pending;
    logic [LANE_BITS-1:0]     lane_idx;
    logic                     last_lane;
    logic                     lane_fire;

    // Current tag decode
    tag_t                     cur_tag;
    logic [CHANNEL_BITS-1:0]  ch_mag;
    logic                     ch_in_range;
    logic [IDX_BITS-1:0]      ch_idx;

    // Counters and last time
    logic [COUNT_BITS-1:0]    rise_cnt [NUM_CHANNELS];
    logic [COUNT_BITS-1:0]    fall_cnt [NUM_CHANNELS];
    logic [TAG_TIME_BITS-1:0] last_time;

    // Register port
    logic                     reg_take;
    logic                     clear_hit;
    logic [COUNT_BITS-1:0]    rdata_d;

    // Kept lanes of the head beat not yet handled
    assign pending = in_beat_i.keep & ~lane_done;

    // Lowest pending lane goes first
    always_comb begin
        lane_idx = '0;
        for (int i = TC_WORD_WIDTH - 1; i >= 0; i--) begin
            if (pending[i]) begin
                lane_idx = LANE_BITS'(i);
            end
        end
    end

    // At most one pending lane left, also true for an empty keep mask
    assign last_lane = (pending & (pending - 1'b1)) == '0;
    assign in_ready_o = last_lane;
    assign lane_fire = in_valid_i && (pending != '0);

    assign cur_tag = in_beat_i.tag[lane_idx];

    // Magnitude selects the counter, sign selects the edge
    assign ch_mag = cur_tag.channel[CHANNEL_BITS-1] ? -cur_tag.channel : cur_tag.channel;
    assign ch_in_range = (ch_mag != '0) && (ch_mag <= MAX_CH);
    assign ch_idx = IDX_BITS'(ch_mag - 1'b1);

    always_ff @(posedge sys_clk) begin
        if (sys_clk_rst) begin
            lane_done <= '0;
        end else if (in_valid_i) begin
            // Beat leaves on its last lane, so start fresh for the next one
            if (last_lane) begin
                lane_done <= '0;
            end else begin
                lane_done <= lane_done | (TC_WORD_WIDTH'(1) << lane_idx);
            end
        end
    end

    // Register request handshake
    assign reg_take = reg_cyc_i && reg_stb_i && !reg_ack_o;
    assign clear_hit = reg_take && reg_we_i && (reg_addr_i == REG_CLEAR);

    // Clear wins over a tag counted in the same cycle
    always_ff @(posedge sys_clk) begin
        if (sys_clk_rst || clear_hit) begin
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                rise_cnt[i] <= '0;
                fall_cnt[i] <= '0;
            end
            last_time <= '0;
        end else if (lane_fire) begin
            // Skipped channels still move the last time
            last_time <= cur_tag.tag_time;
            if (ch_in_range) begin
                if (cur_tag.channel[CHANNEL_BITS-1]) begin
                    fall_cnt[ch_idx] <= fall_cnt[ch_idx] + 1'b1;
                end else begin
                    rise_cnt[ch_idx] <= rise_cnt[ch_idx] + 1'b1;
                end
            end
        end
    end

    // Read decode, counter banks first
    always_comb begin
        rdata_d = '0;
        if (reg_addr_i[REG_ADDR_BITS-1:IDX_BITS] == REG_RISE_BASE[REG_ADDR_BITS-1:IDX_BITS]) begin
            rdata_d = rise_cnt[reg_addr_i[IDX_BITS-1:0]];
        end else if (reg_addr_i[REG_ADDR_BITS-1:IDX_BITS]
                     == REG_FALL_BASE[REG_ADDR_BITS-1:IDX_BITS]) begin
            rdata_d = fall_cnt[reg_addr_i[IDX_BITS-1:0]];
        end else begin
            case (reg_addr_i)
                REG_ID:           rdata_d = DESIGN_ID;
                REG_FIFO_DEPTH:   rdata_d = COUNT_BITS'(TAG_FIFO_DEPTH);
                REG_LAST_TIME_LO: rdata_d = last_time[COUNT_BITS-1:0];
                REG_LAST_TIME_HI: rdata_d = last_time[TAG_TIME_BITS-1:COUNT_BITS];
                default:          rdata_d = '0;
            endcase
        end
    end

    // Single-cycle ack
    always_ff @(posedge sys_clk) begin
        if (sys_clk_rst) begin
            reg_ack_o <= 1'b0;
        end else begin
            reg_ack_o <= reg_take;
        end
    end

    // Read data lands together with the ack
    always_ff @(posedge sys_clk) begin
        if (reg_take && !reg_we_i) begin
            reg_rdata_o <= rdata_d;
        end
    end

endmodule

/* hw/tag_fifo.sv */
module tag_fifo #(
    parameter int DEPTH = tag_pkg::TAG_FIFO_DEPTH
) (
    input  logic               sys_clk,
    input  logic               sys_clk_rst,
    input  logic               wr_valid_i,
    input  tag_pkg::tag_beat_t wr_beat_i,
    output logic               wr_ready_o,
    output logic               rd_valid_o,
    output tag_pkg::tag_beat_t rd_beat_o,
    input  logic               rd_ready_i
);
    import tag_pkg::*;

    // Pointer width; DEPTH is a power of two so pointers wrap by themselves
    localparam int AW = $clog2(DEPTH);
    localparam logic [AW:0] FULL_COUNT = DEPTH[AW:0];

    tag_beat_t   mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    // Occupancy, one bit wider than the pointers
    logic [AW:0]   count;
    logic          wr_fire;
    logic          rd_fire;

    // Show-ahead output, head entry always visible
    assign rd_valid_o = count != '0;
    assign rd_beat_o = mem[rd_ptr];

    // Full FIFO still takes a write when the head leaves in the same cycle
    assign wr_ready_o = (count != FULL_COUNT) || rd_ready_i;

    assign wr_fire = wr_valid_i && wr_ready_o;
    assign rd_fire = rd_valid_o && rd_ready_i;

    // Storage array
    always_ff @(posedge sys_clk) begin
        if (wr_fire) begin
            mem[wr_ptr] <= wr_beat_i;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge sys_clk) begin
        if (sys_clk_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous read and write leaves the count unchanged
            case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* hw/tag_converter.sv */
module tag_converter (
    input  logic                                                         sys_clk,
    input  logic                                                         sys_clk_rst,
    input  logic                                                         in_valid_i,
    input  logic [tag_pkg::TC_WORD_WIDTH-1:0]                            in_keep_i,
    input  logic [tag_pkg::TC_WORD_WIDTH-1:0][tag_pkg::TAG_WORD_BITS-1:0] in_words_i,
    input  logic [tag_pkg::WRAP_BITS-1:0]                                in_wrap_i,
    output logic                                                         in_ready_o,
    output logic                                                         out_valid_o,
    output tag_pkg::tag_beat_t                                           out_beat_o,
    input  logic                                                         out_ready_i
);
    import tag_pkg::*;

    // Zero bits above the wrap count in the 64-bit time
    localparam int PAD_BITS = TAG_TIME_BITS - WRAP_BITS - FINE_TIME_BITS;

    tag_beat_t beat_d;
    logic      in_fire;

    // Decode every lane, kept or not; the keep mask travels alongside
    always_comb begin
        beat_d.keep = in_keep_i;
        for (int i = 0; i < TC_WORD_WIDTH; i++) begin
            // Signed channel in the top bits
            beat_d.tag[i].channel = in_words_i[i][TAG_WORD_BITS-1 -: CHANNEL_BITS];
            // Wrap count above the fine time, zero extended
            beat_d.tag[i].tag_time = {
                {PAD_BITS{1'b0}},
                in_wrap_i,
                in_words_i[i][FINE_TIME_BITS-1:0]
            };
        end
    end

    // Stage accepts when empty or when its content leaves this cycle
    assign in_ready_o = !out_valid_o || out_ready_i;
    assign in_fire = in_valid_i && in_ready_o;

    // Valid flag of the single pipeline stage
    always_ff @(posedge sys_clk) begin
        if (sys_clk_rst) begin
            out_valid_o <= 1'b0;
        end else if (in_ready_o) begin
            out_valid_o <= in_valid_i;
        end
    end

    // Payload only loads on a transfer
    always_ff @(posedge sys_clk) begin
        if (in_fire) begin
            out_beat_o <= beat_d;
        end
    end

endmodule

/* hw/tag_pkg.sv */
package tag_pkg;

    // Stream geometry
    localparam int TC_WORD_WIDTH = 4;
    localparam int TAG_WORD_BITS = 32;

    // Packed word layout, channel on top and fine time below
    localparam int CHANNEL_BITS = 6;
    localparam int FINE_TIME_BITS = 26;
    localparam int WRAP_BITS = 32;
    localparam int TAG_TIME_BITS = 64;

    // Channels 1..8 rising, -1..-8 falling
    localparam int NUM_CHANNELS = 8;

    localparam int TAG_FIFO_DEPTH = 16;

    // Register port widths
    localparam int COUNT_BITS = 32;
    localparam int REG_ADDR_BITS = 8;

    localparam logic [COUNT_BITS-1:0] DESIGN_ID = 32'd1;

    // Register map
    localparam logic [REG_ADDR_BITS-1:0] REG_ID = 8'h00;
    localparam logic [REG_ADDR_BITS-1:0] REG_FIFO_DEPTH = 8'h01;
    localparam logic [REG_ADDR_BITS-1:0] REG_LAST_TIME_LO = 8'h02;
    localparam logic [REG_ADDR_BITS-1:0] REG_LAST_TIME_HI = 8'h03;
    localparam logic [REG_ADDR_BITS-1:0] REG_CLEAR = 8'h04;
    localparam logic [REG_ADDR_BITS-1:0] REG_RISE_BASE = 8'h10;
    localparam logic [REG_ADDR_BITS-1:0] REG_FALL_BASE = 8'h18;

    // One decoded tag
    typedef struct packed {
        logic signed [CHANNEL_BITS-1:0] channel;
        logic [TAG_TIME_BITS-1:0]       tag_time;
    } tag_t;

    // Decoded beat with its lane keep mask
    typedef struct packed {
        tag_t [TC_WORD_WIDTH-1:0] tag;
        logic [TC_WORD_WIDTH-1:0] keep;
    } tag_beat_t;

endpackage
